// File: src/issueQueue_settings.svh
`ifndef ISSUE_QUEUE_SETTINGS_SVH
`define ISSUE_QUEUE_SETTINGS_SVH

// Queue geometry
`define IQ_DEPTH 32
`define IQ_LANES 4

// Field widths
`define ROB_IDX_W 7
`define PREG_W 8
`define SLOT_W 5

`endif

// File: src/issuePkg.sv
`include "issueQueue_settings.svh"

package issuePkg;

    typedef logic [`ROB_IDX_W-1:0] robIdxT;
    typedef logic [`PREG_W-1:0] pregT;
    typedef logic [`SLOT_W-1:0] slotIdxT;
    typedef logic [`IQ_DEPTH-1:0] slotMaskT;

    // One micro-op from the dispatcher
    typedef struct packed {
        logic   valid;
        robIdxT robIdx;
        pregT   src1;
        pregT   src2;
        logic   src1Ready;
        logic   src2Ready;
    } dispatchLaneT;

    typedef struct packed {
        logic   valid;
        robIdxT robIdx;
    } issueLaneT;

    // Result tag broadcast
    typedef struct packed {
        logic valid;
        pregT tag;
    } wakeupT;

    typedef struct packed {
        logic    valid;
        slotIdxT slot;
    } pickT;

endpackage

// File: src/slotPicker.sv
`timescale 1ns/1ns

`include "issueQueue_settings.svh"

module slotPicker (
    input  issuePkg::slotMaskT mask,
    output issuePkg::pickT     picks [`IQ_LANES]
);
    import issuePkg::*;

    // Bits not yet claimed by an earlier round
    slotMaskT remaining;
    // One-hot of the current round's winner
    slotMaskT lowest;

    // One-hot to binary by ORing the indices of set bits
    function automatic slotIdxT encode(input slotMaskT oneHot);
        slotIdxT idx;
        idx = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (oneHot[i]) begin
                idx = idx | slotIdxT'(i);
            end
        end
        return idx;
    endfunction

    // Four rounds of find-lowest-then-clear
    always_comb begin
        remaining = mask;
        lowest = '0;
        for (int k = 0; k < `IQ_LANES; k++) begin
            // Two's complement trick isolates the lowest set bit
            lowest = remaining & (~remaining + 1'b1);
            picks[k].valid = |remaining;
            picks[k].slot = encode(lowest);
            remaining = remaining & ~lowest;
        end
    end

endmodule

// File: src/entryArray.sv
`timescale 1ns/1ns

`include "issueQueue_settings.svh"

module entryArray (
    input  logic                   clk,
    input  logic                   reset,
    input  issuePkg::dispatchLaneT dispatch [`IQ_LANES],
    input  issuePkg::wakeupT       wakeup,
    input  issuePkg::pickT         freePicks [`IQ_LANES],
    input  issuePkg::pickT         readyPicks [`IQ_LANES],
    output issuePkg::slotMaskT     occupied,
    output issuePkg::slotMaskT     readyMask,
    output issuePkg::issueLaneT    issue [`IQ_LANES],
    output logic [2:0]             creditReturn
);
    import issuePkg::*;

    // Slot state
    slotMaskT busy;
    slotMaskT src1Ready;
    slotMaskT src2Ready;
    robIdxT   robIdx [`IQ_DEPTH];
    pregT     src1Tag [`IQ_DEPTH];
    pregT     src2Tag [`IQ_DEPTH];

    slotMaskT nextBusy;
    slotMaskT nextSrc1Ready;
    slotMaskT nextSrc2Ready;

    logic [`IQ_LANES-1:0] insertEn;
    logic [`IQ_LANES-1:0] issueValid;
    robIdxT               issueRob [`IQ_LANES];
    logic [2:0]           issueCount;

    function automatic logic tagHit(input wakeupT bcast, input pregT tag);
        return bcast.valid && (bcast.tag == tag);
    endfunction

    assign occupied = busy;
    assign readyMask = busy & src1Ready & src2Ready;

    always_comb begin
        for (int k = 0; k < `IQ_LANES; k++) begin
            insertEn[k] = dispatch[k].valid && freePicks[k].valid;
        end
    end

    // Lanes leaving this cycle give the credit return
    always_comb begin
        issueCount = '0;
        for (int k = 0; k < `IQ_LANES; k++) begin
            issueCount = issueCount + {2'b0, readyPicks[k].valid};
        end
    end

    always_comb begin
        nextBusy = busy;
        nextSrc1Ready = src1Ready;
        nextSrc2Ready = src2Ready;
        // Wakeup of stored sources
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (tagHit(wakeup, src1Tag[i])) begin
                nextSrc1Ready[i] = 1'b1;
            end
            if (tagHit(wakeup, src2Tag[i])) begin
                nextSrc2Ready[i] = 1'b1;
            end
        end
        // Selected entries leave
        for (int k = 0; k < `IQ_LANES; k++) begin
            if (readyPicks[k].valid) begin
                nextBusy[readyPicks[k].slot] = 1'b0;
            end
        end
        // Free picks only cover empty slots and never clash with the frees above
        for (int k = 0; k < `IQ_LANES; k++) begin
            if (insertEn[k]) begin
                nextBusy[freePicks[k].slot] = 1'b1;
                nextSrc1Ready[freePicks[k].slot] =
                    dispatch[k].src1Ready || tagHit(wakeup, dispatch[k].src1);
                nextSrc2Ready[freePicks[k].slot] =
                    dispatch[k].src2Ready || tagHit(wakeup, dispatch[k].src2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= '0;
            src1Ready <= '0;
            src2Ready <= '0;
            issueValid <= '0;
            creditReturn <= '0;
        end else begin
            busy <= nextBusy;
            src1Ready <= nextSrc1Ready;
            src2Ready <= nextSrc2Ready;
            creditReturn <= issueCount;
            for (int k = 0; k < `IQ_LANES; k++) begin
                issueValid[k] <= readyPicks[k].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `IQ_LANES; k++) begin
            if (insertEn[k]) begin
                robIdx[freePicks[k].slot] <= dispatch[k].robIdx;
                src1Tag[freePicks[k].slot] <= dispatch[k].src1;
                src2Tag[freePicks[k].slot] <= dispatch[k].src2;
            end
            issueRob[k] <= robIdx[readyPicks[k].slot];
        end
    end

    always_comb begin
        for (int k = 0; k < `IQ_LANES; k++) begin
            issue[k].valid = issueValid[k];
            issue[k].robIdx = issueRob[k];
        end
    end

endmodule

// File: src/issueQueue.sv
`timescale 1ns/1ns

`include "issueQueue_settings.svh"

module issueQueue (
    input  logic                   clk,
    input  logic                   reset,
    input  issuePkg::dispatchLaneT dispatch [`IQ_LANES],
    input  issuePkg::wakeupT       wakeup,
    output issuePkg::issueLaneT    issue [`IQ_LANES],
    output logic [2:0]             creditReturn
);
    import issuePkg::*;

    slotMaskT occupied;
    slotMaskT freeMask;
    slotMaskT readyMask;

    // Pick k of the free picker serves dispatch lane k
    pickT freePicks [`IQ_LANES];
    // Pick k of the ready picker drives issue lane k
    pickT readyPicks [`IQ_LANES];

    assign freeMask = ~occupied;

    // Lowest empty slots for insertion
    slotPicker freePicker (
        .mask  (freeMask),
        .picks (freePicks)
    );

    // Lowest slots with both sources ready
    slotPicker readyPicker (
        .mask  (readyMask),
        .picks (readyPicks)
    );

    entryArray entries (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .wakeup       (wakeup),
        .freePicks    (freePicks),
        .readyPicks   (readyPicks),
        .occupied     (occupied),
        .readyMask    (readyMask),
        .issue        (issue),
        .creditReturn (creditReturn)
    );

endmodule

// File: tb/issueChecker.sv
`timescale 1ns/1ns

`include "issueQueue_settings.svh"

module issueChecker (
    input  logic                   clk,
    input  logic                   reset,
    input  issuePkg::dispatchLaneT dispatch [`IQ_LANES],
    input  issuePkg::wakeupT       wakeup,
    input  issuePkg::issueLaneT    issue [`IQ_LANES],
    input  logic [2:0]             creditReturn,
    output int                     errors,
    output int                     checks
);
    import issuePkg::*;

    // Reference copy of the slots
    logic   busy [`IQ_DEPTH];
    logic   wasBusy [`IQ_DEPTH];
    logic   ready1 [`IQ_DEPTH];
    logic   ready2 [`IQ_DEPTH];
    robIdxT rob [`IQ_DEPTH];
    pregT   tag1 [`IQ_DEPTH];
    pregT   tag2 [`IQ_DEPTH];

    issueLaneT  expIssue [`IQ_LANES];
    logic [2:0] expCredit;
    logic       started;
    int         picked;
    int         slot;
    int         validLanes;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        started = 1'b0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                busy[i] = 1'b0;
            end
            for (int k = 0; k < `IQ_LANES; k++) begin
                expIssue[k] = '0;
            end
            expCredit = '0;
            started = 1'b1;
        end else if (started) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                wasBusy[i] = busy[i];
            end
            // Lowest ready slots leave first
            picked = 0;
            for (int k = 0; k < `IQ_LANES; k++) begin
                expIssue[k] = '0;
            end
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (busy[i] && ready1[i] && ready2[i] && picked < `IQ_LANES) begin
                    expIssue[picked].valid = 1'b1;
                    expIssue[picked].robIdx = rob[i];
                    busy[i] = 1'b0;
                    picked++;
                end
            end
            expCredit = 3'(picked);
            if (wakeup.valid) begin
                for (int i = 0; i < `IQ_DEPTH; i++) begin
                    if (tag1[i] == wakeup.tag) ready1[i] = 1'b1;
                    if (tag2[i] == wakeup.tag) ready2[i] = 1'b1;
                end
            end
            // New micro-ops fill slots that were empty before this edge
            slot = 0;
            for (int k = 0; k < `IQ_LANES; k++) begin
                if (dispatch[k].valid) begin
                    while (slot < `IQ_DEPTH && wasBusy[slot]) slot++;
                    if (slot == `IQ_DEPTH) begin
                        errors++;
                        $display("Dispatch lane %0d arrived with no free slot left", k);
                    end else begin
                        busy[slot] = 1'b1;
                        rob[slot] = dispatch[k].robIdx;
                        tag1[slot] = dispatch[k].src1;
                        tag2[slot] = dispatch[k].src2;
                        ready1[slot] = dispatch[k].src1Ready ||
                            (wakeup.valid && wakeup.tag == dispatch[k].src1);
                        ready2[slot] = dispatch[k].src2Ready ||
                            (wakeup.valid && wakeup.tag == dispatch[k].src2);
                        slot++;
                    end
                end
            end
        end
    end

    // Outputs are compared half a cycle after the rising edge
    always @(negedge clk) begin
        if (started) begin
            validLanes = 0;
            for (int k = 0; k < `IQ_LANES; k++) begin
                compare($sformatf("issue[%0d].valid", k), 32'(expIssue[k].valid),
                        32'(issue[k].valid));
                if (expIssue[k].valid) begin
                    compare($sformatf("issue[%0d].robIdx", k), 32'(expIssue[k].robIdx),
                            32'(issue[k].robIdx));
                end
                if (issue[k].valid === 1'b1) validLanes++;
            end
            compare("creditReturn", 32'(expCredit), 32'(creditReturn));
            compare("creditReturn vs valid lanes", 32'(validLanes), 32'(creditReturn));
        end
    end

endmodule

// File: tb/issueQueueTb.sv
`timescale 1ns/1ns

`include "issueQueue_settings.svh"

module issueQueueTb;
    import issuePkg::*;

    // Lane k of a row uses tag1 + k and tag2 + k
    typedef struct packed {
        logic [2:0] lanes;
        logic       drawn;
        logic [3:0] ready1;
        logic [3:0] ready2;
        pregT       tag1;
        pregT       tag2;
        wakeupT     wake;
    } rowT;

    logic         clk;
    logic         reset;
    dispatchLaneT dispatch [`IQ_LANES];
    wakeupT       wakeup;
    issueLaneT    issue [`IQ_LANES];
    logic [2:0]   creditReturn;

    rowT         rows [$];
    int          credits;
    robIdxT      nextRob;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          otherErrors;
    int          drainCycles;

    issueQueue uut (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .wakeup       (wakeup),
        .issue        (issue),
        .creditReturn (creditReturn)
    );

    issueChecker scoreboard (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .wakeup       (wakeup),
        .issue        (issue),
        .creditReturn (creditReturn),
        .errors       (errors),
        .checks       (checks)
    );

    always #2 clk = ~clk;

    // Galois LFSR stepped once for each bit taken
    function automatic logic [7:0] drawBits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[6:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic addRow(input int lanes, input logic drawn, input logic [3:0] ready1,
                          input logic [3:0] ready2, input pregT tag1, input pregT tag2,
                          input logic wakeValid, input pregT wakeTag);
        rowT entry;
        entry.lanes = 3'(lanes);
        entry.drawn = drawn;
        entry.ready1 = ready1;
        entry.ready2 = ready2;
        entry.tag1 = tag1;
        entry.tag2 = tag2;
        entry.wake.valid = wakeValid;
        entry.wake.tag = wakeTag;
        rows.push_back(entry);
    endtask

    // Credits come back one cycle at a time
    task automatic nextCycle();
        @(negedge clk);
        credits = credits + int'(creditReturn);
        if (credits > `IQ_DEPTH) begin
            otherErrors++;
            $display("More credits came back than were spent (%0d)", credits);
        end
    endtask

    task automatic applyRow(input rowT entry);
        int count;
        count = (int'(entry.lanes) < credits) ? int'(entry.lanes) : credits;
        for (int k = 0; k < `IQ_LANES; k++) begin
            dispatch[k] = '0;
            if (k < count) begin
                dispatch[k].valid = 1'b1;
                dispatch[k].robIdx = nextRob;
                nextRob = nextRob + robIdxT'(1);
                if (entry.drawn) begin
                    dispatch[k].src1 = drawBits(8);
                    dispatch[k].src2 = drawBits(8);
                    dispatch[k].src1Ready = 1'(drawBits(1));
                    dispatch[k].src2Ready = 1'(drawBits(1));
                end else begin
                    dispatch[k].src1 = entry.tag1 + pregT'(k);
                    dispatch[k].src2 = entry.tag2 + pregT'(k);
                    dispatch[k].src1Ready = entry.ready1[k];
                    dispatch[k].src2Ready = entry.ready2[k];
                end
            end
        end
        wakeup = entry.wake;
        if (entry.drawn) begin
            wakeup.valid = 1'b1;
            wakeup.tag = drawBits(8);
        end
        credits = credits - count;
    endtask

    task automatic buildTable();
        repeat (2) addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 0, 8'h00);
        addRow(1, 0, 4'hf, 4'hf, 8'h01, 8'h02, 0, 8'h00);
        // Second sources wait on tags 10 and 11
        addRow(2, 0, 4'hf, 4'h0, 8'h03, 8'h10, 0, 8'h00);
        addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 1, 8'h10);
        // Woken by the broadcast in its own dispatch cycle
        addRow(1, 0, 4'h1, 4'h0, 8'h05, 8'h20, 1, 8'h20);
        addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 1, 8'h11);
        // Fill every slot until the credit count cuts the last row
        repeat (9) addRow(4, 0, 4'h0, 4'h0, 8'h40, 8'h50, 0, 8'h00);
        for (int t = 0; t < 4; t++) addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 1, 8'h40 + 8'(t));
        for (int t = 0; t < 4; t++) addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 1, 8'h50 + 8'(t));
        repeat (3) addRow(0, 0, 4'h0, 4'h0, 8'h00, 8'h00, 0, 8'h00);
        repeat (12) addRow(3, 1, 4'h0, 4'h0, 8'h00, 8'h00, 0, 8'h00);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        wakeup = '0;
        for (int k = 0; k < `IQ_LANES; k++) begin
            dispatch[k] = '0;
        end
        credits = `IQ_DEPTH;
        nextRob = '0;
        lfsr = 32'he06d;
        otherErrors = 0;
        buildTable();
        repeat (10) @(negedge clk);
        reset = 1'b1;
        foreach (rows[i]) begin
            nextCycle();
            applyRow(rows[i]);
        end
        // Sweep broadcast tags until every entry has left
        drainCycles = 0;
        while (credits != `IQ_DEPTH && drainCycles < 600) begin
            nextCycle();
            for (int k = 0; k < `IQ_LANES; k++) begin
                dispatch[k] = '0;
            end
            wakeup.valid = 1'b1;
            wakeup.tag = pregT'(drainCycles);
            drainCycles++;
        end
        if (credits != `IQ_DEPTH) begin
            otherErrors++;
            $display("Timed out in drain with %0d of %0d credits back", credits, `IQ_DEPTH);
        end
        wakeup = '0;
        repeat (3) @(negedge clk);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, errors, otherErrors);
        if (errors == 0 && otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: issueQueue.f
+incdir+src
src/issuePkg.sv
src/slotPicker.sv
src/entryArray.sv
src/issueQueue.sv
tb/issueChecker.sv
tb/issueQueueTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= issueQueueTb
FILELIST   ?= issueQueue.f
BUILD_DIR  ?= obj_dir
BUILD_FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Testbench passed

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
